//--- all.f
src/spi_pu_pkg.sv
src/spi_slave_driver.sv
src/spi_buffer.sv
src/hoarder.sv
src/byte_collector.sv
src/spi_pu_control.sv
src/pu_slave_spi.sv
test/tb_pu_slave_spi.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the SPI processing unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pu_slave_spi -f all.f \
    --Mdir obj_dir -o sim_pu_slave_spi
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_pu_slave_spi 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
echo "Pass message not found in the simulator output"
exit 1

//--- test/tb_pu_slave_spi.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pu_slave_spi
    import spi_pu_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CLKS = 8;
    localparam int HALF_CLKS  = 5;
    localparam int SETUP_CLKS = 10;
    localparam int STOP_WAIT  = 20;
    localparam int MID_CLKS   = 40;
    localparam int N_ENTRIES  = 8;
    localparam int MAX_BYTES  = 28;
    localparam int ENTRY_CLKS = MAX_BYTES * SPI_DATA_WIDTH * 2 * HALF_CLKS + 300;
    localparam longint TIMEOUT_NS = longint'(RESET_CLKS + N_ENTRIES * ENTRY_CLKS + 200)
                                    * CLK_PERIOD;

    typedef struct {
        int n_words;
        bit cycle_before;
        int n_bytes;
        bit cycle_during;
    } entry_t;

    logic      clk;
    logic      rst;
    logic      signal_cycle;
    logic      signal_wr;
    word_t     data_in;
    logic      signal_oe;
    word_t     data_out;
    attr_t     attr_out;
    logic      flag_start;
    logic      flag_stop;
    logic      mosi;
    logic      miso;
    logic      sclk;
    logic      cs;

    entry_t    tests [N_ENTRIES];
    word_t     pending_q [$];
    word_t     frame_q [$];
    spi_byte_t mosi_q [$];
    spi_byte_t miso_q [$];
    int        start_cnt;
    int        stop_cnt;

    pu_slave_spi pu_slave_spi_i (
        .clk          (clk),
        .rst          (rst),
        .signal_cycle (signal_cycle),
        .signal_wr    (signal_wr),
        .data_in      (data_in),
        .signal_oe    (signal_oe),
        .data_out     (data_out),
        .attr_out     (attr_out),
        .flag_start   (flag_start),
        .flag_stop    (flag_stop),
        .mosi         (mosi),
        .miso         (miso),
        .sclk         (sclk),
        .cs           (cs)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        report_failure("watchdog expired before all entries were applied");
    end

    // Flag pulses counted away from the rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (flag_start) start_cnt = start_cnt + 1;
            if (flag_stop) stop_cnt = stop_cnt + 1;
        end
    end

    // ---------------------------------------------------------------------------
    // Compare tasks
    // ---------------------------------------------------------------------------

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    task automatic check_byte(input string name, input spi_byte_t got, input spi_byte_t exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    task automatic check_attr(input string name, input attr_t got, input attr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("MISMATCH %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    // ---------------------------------------------------------------------------
    // Host side and SPI master model
    // ---------------------------------------------------------------------------

    task automatic host_write(input word_t w);
        @(posedge clk);
        signal_wr <= 1'b1;
        data_in   <= w;
        @(posedge clk);
        signal_wr <= 1'b0;
    endtask

    task automatic pulse_cycle();
        @(posedge clk);
        signal_cycle <= 1'b1;
        @(posedge clk);
        signal_cycle <= 1'b0;
    endtask

    // Bit k of the mosi stream with each byte sent MSB first
    function automatic logic mosi_bit(input int k);
        spi_byte_t b;
        b = mosi_q[k / SPI_DATA_WIDTH];
        return b[SPI_DATA_WIDTH - 1 - (k % SPI_DATA_WIDTH)];
    endfunction

    // Mode 0 master that changes mosi with the falling sclk
    task automatic spi_transfer(input int n_bytes);
        spi_byte_t got;
        int        k;
        miso_q.delete();
        @(posedge clk);
        cs   <= 1'b0;
        mosi <= (n_bytes > 0) ? mosi_bit(0) : 1'b0;
        repeat (SETUP_CLKS) @(posedge clk);
        for (int b = 0; b < n_bytes; b++) begin
            for (int i = SPI_DATA_WIDTH - 1; i >= 0; i--) begin
                @(negedge clk);
                got[i] = miso;
                @(posedge clk);
                sclk <= 1'b1;
                repeat (HALF_CLKS) @(posedge clk);
                sclk <= 1'b0;
                k = b * SPI_DATA_WIDTH + (SPI_DATA_WIDTH - i);
                if (k < n_bytes * SPI_DATA_WIDTH) mosi <= mosi_bit(k);
                repeat (HALF_CLKS) @(posedge clk);
            end
            miso_q.push_back(got);
        end
        cs   <= 1'b1;
        mosi <= 1'b0;
    endtask

    task automatic wait_stop();
        int n;
        n = 0;
        @(negedge clk);
        while (!flag_stop) begin
            n++;
            if (n > STOP_WAIT) report_failure("flag_stop did not follow the rise of cs");
            @(negedge clk);
        end
    endtask

    // Frame words go out top byte first, zero once the frame runs dry
    task automatic check_tx(input int n_bytes);
        spi_byte_t exp;
        int        w;
        for (int b = 0; b < n_bytes; b++) begin
            w   = b / BYTES_PER_WORD;
            exp = '0;
            if (w < frame_q.size()) begin
                exp = frame_q[w][DATA_WIDTH - 1 - SPI_DATA_WIDTH * (b % BYTES_PER_WORD)
                                 -: SPI_DATA_WIDTH];
            end
            check_byte($sformatf("miso byte %0d", b), miso_q[b], exp);
        end
    endtask

    task automatic read_rx(input int n_bytes);
        word_t exp;
        attr_t valid_attr;
        attr_t empty_attr;
        valid_attr = '0;
        empty_attr = '0;
        empty_attr[INVALID] = 1'b1;
        for (int i = 0; i < n_bytes / BYTES_PER_WORD; i++) begin
            exp = {mosi_q[4 * i], mosi_q[4 * i + 1], mosi_q[4 * i + 2], mosi_q[4 * i + 3]};
            @(negedge clk);
            check_attr("attr_out", attr_out, valid_attr);
            check_word("data_out", data_out, exp);
            @(posedge clk);
            signal_oe <= 1'b1;
            @(posedge clk);
            signal_oe <= 1'b0;
        end
        @(negedge clk);
        check_attr("attr_out", attr_out, empty_attr);
    endtask

    // ---------------------------------------------------------------------------
    // Stimulus table and main sequence
    // ---------------------------------------------------------------------------

    initial begin
        word_t rnd;
        word_t mid_word;
        int    starts;
        int    stops;
        attr_t empty_attr;

        rnd = $urandom(32'h8386d374);
        rst = 1'b1;
        signal_cycle = 1'b0;
        signal_wr = 1'b0;
        data_in = '0;
        signal_oe = 1'b0;
        mosi = 1'b0;
        sclk = 1'b0;
        cs = 1'b1;
        start_cnt = 0;
        stop_cnt = 0;
        empty_attr = '0;
        empty_attr[INVALID] = 1'b1;

        // Words, swap before, master bytes, swap attempt during the frame
        tests[0] = '{3, 1'b1, 12, 1'b0};
        tests[1] = '{2, 1'b0, 14, 1'b0};
        tests[2] = '{0, 1'b1,  8, 1'b1};
        tests[3] = '{5, 1'b1, 26, 1'b0};
        tests[4] = '{0, 1'b0,  3, 1'b0};
        tests[5] = '{1, 1'b1,  4, 1'b1};
        tests[6] = '{0, 1'b1,  6, 1'b0};
        tests[7] = '{6, 1'b1, 24, 1'b0};

        repeat (RESET_CLKS) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("flag_start", flag_start, 1'b0);
        check_bit("flag_stop", flag_stop, 1'b0);
        check_bit("miso", miso, 1'b0);
        check_attr("attr_out", attr_out, empty_attr);

        for (int e = 0; e < N_ENTRIES; e++) begin
            for (int i = 0; i < tests[e].n_words; i++) begin
                rnd = $urandom;
                host_write(rnd);
                pending_q.push_back(rnd);
            end
            // Swap only happens with cs high, the written buffer becomes the frame
            if (tests[e].cycle_before) begin
                pulse_cycle();
                frame_q = pending_q;
                pending_q.delete();
            end
            mosi_q.delete();
            for (int i = 0; i < tests[e].n_bytes; i++) begin
                mosi_q.push_back(spi_byte_t'($urandom));
            end
            repeat (4) @(posedge clk);
            starts = start_cnt;
            stops  = stop_cnt;
            if (tests[e].cycle_during) begin
                mid_word = $urandom;
                fork
                    spi_transfer(tests[e].n_bytes);
                    begin
                        repeat (MID_CLKS) @(posedge clk);
                        pulse_cycle();
                        host_write(mid_word);
                    end
                join
                // Ignored swap, so the word waits for the next cycle
                pending_q.push_back(mid_word);
            end else begin
                spi_transfer(tests[e].n_bytes);
            end
            wait_stop();
            repeat (4) @(posedge clk);
            check_count("flag_start pulses", start_cnt - starts, 1);
            check_count("flag_stop pulses", stop_cnt - stops, 1);
            check_tx(tests[e].n_bytes);
            read_rx(tests[e].n_bytes);
        end

        repeat (4) @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/pu_slave_spi.sv
`timescale 1ns/1ns
`default_nettype none

module pu_slave_spi
    import spi_pu_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  signal_cycle,

    // Host side
    input  logic  signal_wr,
    input  word_t data_in,
    input  logic  signal_oe,
    output word_t data_out,
    output attr_t attr_out,
    output logic  flag_start,
    output logic  flag_stop,

    // SPI side
    input  logic  mosi,
    output logic  miso,
    input  logic  sclk,
    input  logic  cs
);

    spi_byte_t tx_byte;
    spi_byte_t rx_byte;
    logic      byte_done;
    logic      cs_fall;
    logic      cs_rise;

    logic      sel_send;
    logic      wr_a, wr_b;
    logic      pop_a, pop_b;
    logic      clear_a, clear_b;
    logic      rewind_send;
    logic      clear_rx;
    logic      word_req;

    word_t     a_data, b_data;
    logic      a_empty, b_empty;
    word_t     send_word;
    logic      send_empty;

    logic      word_wr;
    word_t     rx_word;
    logic      rx_empty;

    // -------------------------------------------------------------------------
    // SPI pins
    // -------------------------------------------------------------------------

    spi_slave_driver spi_driver (
        .clk       (clk),
        .rst       (rst),
        .mosi      (mosi),
        .sclk      (sclk),
        .cs        (cs),
        .tx_byte   (tx_byte),
        .miso      (miso),
        .rx_byte   (rx_byte),
        .byte_done (byte_done),
        .cs_fall   (cs_fall),
        .cs_rise   (cs_rise)
    );

    spi_pu_control control (
        .clk          (clk),
        .rst          (rst),
        .signal_cycle (signal_cycle),
        .signal_wr    (signal_wr),
        .cs_fall      (cs_fall),
        .cs_rise      (cs_rise),
        .word_req     (word_req),
        .sel_send     (sel_send),
        .wr_a         (wr_a),
        .wr_b         (wr_b),
        .pop_a        (pop_a),
        .pop_b        (pop_b),
        .clear_a      (clear_a),
        .clear_b      (clear_b),
        .rewind_send  (rewind_send),
        .clear_rx     (clear_rx),
        .flag_start   (flag_start),
        .flag_stop    (flag_stop)
    );

    // -------------------------------------------------------------------------
    // Transmit ping-pong pair
    // -------------------------------------------------------------------------

    spi_buffer buf_a (
        .clk      (clk),
        .rst      (rst),
        .clear    (clear_a),
        .rewind   (rewind_send && !sel_send),
        .wr       (wr_a),
        .data_in  (data_in),
        .pop      (pop_a),
        .data_out (a_data),
        .empty    (a_empty)
    );

    spi_buffer buf_b (
        .clk      (clk),
        .rst      (rst),
        .clear    (clear_b),
        .rewind   (rewind_send && sel_send),
        .wr       (wr_b),
        .data_in  (data_in),
        .pop      (pop_b),
        .data_out (b_data),
        .empty    (b_empty)
    );

    // Hoarder sees whichever buffer is being sent
    assign send_word  = sel_send ? b_data : a_data;
    assign send_empty = sel_send ? b_empty : a_empty;

    hoarder frame_hoarder (
        .clk        (clk),
        .rst        (rst),
        .load_first (flag_start),
        .byte_done  (byte_done),
        .word_in    (send_word),
        .word_empty (send_empty),
        .tx_byte    (tx_byte),
        .word_req   (word_req)
    );

    // -------------------------------------------------------------------------
    // Receive path
    // -------------------------------------------------------------------------

    byte_collector collector (
        .clk         (clk),
        .rst         (rst),
        .byte_done   (byte_done),
        .rx_byte     (rx_byte),
        .frame_start (cs_rise),
        .word_wr     (word_wr),
        .word_out    (rx_word)
    );

    spi_buffer rx_buf (
        .clk      (clk),
        .rst      (rst),
        .clear    (clear_rx),
        .rewind   (1'b0),
        .wr       (word_wr),
        .data_in  (rx_word),
        .pop      (signal_oe),
        .data_out (data_out),
        .empty    (rx_empty)
    );

    always_comb begin
        attr_out          = '0;
        attr_out[INVALID] = rx_empty;
    end

endmodule

`default_nettype wire

//--- src/spi_pu_control.sv
`timescale 1ns/1ns
`default_nettype none

module spi_pu_control
    import spi_pu_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic signal_cycle,
    input  logic signal_wr,
    input  logic cs_fall,
    input  logic cs_rise,
    input  logic word_req,
    output logic sel_send,
    output logic wr_a,
    output logic wr_b,
    output logic pop_a,
    output logic pop_b,
    output logic clear_a,
    output logic clear_b,
    output logic rewind_send,
    output logic clear_rx,
    output logic flag_start,
    output logic flag_stop
);

    link_state_t state;
    logic        swap;

    // -------------------------------------------------------------------------
    // Link state
    // -------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= LINK_IDLE;
        end else begin
            case (state)
                LINK_IDLE:   if (cs_fall) state <= LINK_ACTIVE;
                LINK_ACTIVE: if (cs_rise) state <= LINK_IDLE;
                default:     state <= LINK_IDLE;
            endcase
        end
    end

    // -------------------------------------------------------------------------
    // Buffer selection
    // -------------------------------------------------------------------------

    // sel_send low means buf_a is being sent
    assign swap = signal_cycle && (state == LINK_IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_send <= 1'b0;
        end else if (swap) begin
            sel_send <= ~sel_send;
        end
    end

    // The buffer being sent now becomes the host's, so it starts empty
    assign clear_a = swap && !sel_send;
    assign clear_b = swap && sel_send;

    // Host writes the idle buffer, the hoarder drains the sent one
    assign wr_a  = signal_wr && sel_send;
    assign wr_b  = signal_wr && !sel_send;
    assign pop_a = word_req && !sel_send;
    assign pop_b = word_req && sel_send;

    // -------------------------------------------------------------------------
    // Transaction pulses
    // -------------------------------------------------------------------------

    // Rewind also at the stop so the read pointer is at 0 for the next start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flag_start  <= 1'b0;
            flag_stop   <= 1'b0;
            rewind_send <= 1'b0;
            clear_rx    <= 1'b0;
        end else begin
            flag_start  <= cs_fall;
            flag_stop   <= cs_rise;
            rewind_send <= cs_fall || cs_rise;
            clear_rx    <= cs_fall;
        end
    end

endmodule

`default_nettype wire

//--- src/byte_collector.sv
`timescale 1ns/1ns
`default_nettype none

module byte_collector
    import spi_pu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      byte_done,
    input  spi_byte_t rx_byte,
    input  logic      frame_start,
    output logic      word_wr,
    output word_t     word_out
);

    word_t     acc;
    byte_idx_t cnt;

    // Byte counter, restarted whenever the frame boundary is seen
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt     <= '0;
            word_wr <= 1'b0;
        end else begin
            word_wr <= 1'b0;
            if (frame_start) begin
                cnt <= '0;
            end else if (byte_done) begin
                cnt     <= cnt + 1'b1;
                word_wr <= cnt == byte_idx_t'(BYTES_PER_WORD - 1);
            end
        end
    end

    // First byte of a word ends up in the top bits
    always_ff @(posedge clk) begin
        if (byte_done) begin
            acc <= {acc[DATA_WIDTH-SPI_DATA_WIDTH-1:0], rx_byte};
        end
    end

    assign word_out = acc;

endmodule

`default_nettype wire

//--- src/hoarder.sv
`timescale 1ns/1ns
`default_nettype none

module hoarder
    import spi_pu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      load_first,
    input  logic      byte_done,
    input  word_t     word_in,
    input  logic      word_empty,
    output spi_byte_t tx_byte,
    output logic      word_req
);

    word_t     cur_word;
    byte_idx_t idx;
    logic      last_byte;
    logic      load;

    assign last_byte = idx == byte_idx_t'(BYTES_PER_WORD - 1);

    // New word at frame start or once the last byte of the current one is out
    assign load = load_first || (byte_done && last_byte);

    // Pop only when a real word was taken
    assign word_req = load && !word_empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx <= '0;
        end else if (load) begin
            idx <= '0;
        end else if (byte_done) begin
            idx <= idx + 1'b1;
        end
    end

    // Word shifts up a byte at a time, top byte is always the one to send
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_word <= '0;
        end else if (load) begin
            cur_word <= word_empty ? '0 : word_in;
        end else if (byte_done) begin
            cur_word <= {cur_word[DATA_WIDTH-SPI_DATA_WIDTH-1:0], {SPI_DATA_WIDTH{1'b0}}};
        end
    end

    assign tx_byte = cur_word[DATA_WIDTH-1 -: SPI_DATA_WIDTH];

endmodule

`default_nettype wire

//--- src/spi_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module spi_buffer
    import spi_pu_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  clear,
    input  logic  rewind,
    input  logic  wr,
    input  word_t data_in,
    input  logic  pop,
    output word_t data_out,
    output logic  empty
);

    word_t    mem [BUF_SIZE];
    buf_ptr_t wr_ptr;
    buf_ptr_t rd_ptr;
    logic     full;
    logic     do_wr;
    logic     do_pop;

    assign full   = wr_ptr == buf_ptr_t'(BUF_SIZE);
    assign empty  = rd_ptr == wr_ptr;
    assign do_wr  = wr && !full && !clear;
    assign do_pop = pop && !empty;

    // Read pointer may sit at BUF_SIZE, which is only possible when empty
    assign data_out = empty ? '0 : mem[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // A pop in the rewind cycle consumes word 0
            if (rewind) begin
                rd_ptr <= do_pop ? buf_ptr_t'(1) : '0;
            end else if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // Writes past the last slot are dropped
    a_no_overflow : assert property (
        @(posedge clk) disable iff (rst) (wr && !clear) |-> !full
    ) else $error("write to a full buffer dropped");

endmodule

`default_nettype wire

//--- src/spi_slave_driver.sv
`timescale 1ns/1ns
`default_nettype none

module spi_slave_driver
    import spi_pu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      mosi,
    input  logic      sclk,
    input  logic      cs,
    input  spi_byte_t tx_byte,
    output logic      miso,
    output spi_byte_t rx_byte,
    output logic      byte_done,
    output logic      cs_fall,
    output logic      cs_rise
);

    logic sclk_meta, sclk_sync, sclk_prev;
    logic cs_meta, cs_sync, cs_prev;
    logic mosi_meta, mosi_sync;
    logic sclk_rise, sclk_fall;
    logic [$clog2(SPI_DATA_WIDTH)-1:0] bit_cnt;
    logic [1:0] start_q;
    spi_byte_t rx_shift;
    spi_byte_t tx_shift;

    // -------------------------------------------------------------------------
    // Pin synchronizers and edge detection
    // -------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sclk_meta <= 1'b0;
            sclk_sync <= 1'b0;
            sclk_prev <= 1'b0;
            cs_meta   <= 1'b1;
            cs_sync   <= 1'b1;
            cs_prev   <= 1'b1;
            mosi_meta <= 1'b0;
            mosi_sync <= 1'b0;
        end else begin
            sclk_meta <= sclk;
            sclk_sync <= sclk_meta;
            sclk_prev <= sclk_sync;
            cs_meta   <= cs;
            cs_sync   <= cs_meta;
            cs_prev   <= cs_sync;
            mosi_meta <= mosi;
            mosi_sync <= mosi_meta;
        end
    end

    assign cs_fall   = cs_prev & ~cs_sync;
    assign cs_rise   = ~cs_prev & cs_sync;

    // Clock edges only count while the slave is selected
    assign sclk_rise = sclk_sync & ~sclk_prev & ~cs_sync;
    assign sclk_fall = ~sclk_sync & sclk_prev & ~cs_sync;

    // -------------------------------------------------------------------------
    // Receive side, mode 0 samples on the rising edge
    // -------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt   <= '0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (cs_sync) begin
                bit_cnt <= '0;
            end else if (sclk_rise) begin
                bit_cnt   <= bit_cnt + 1'b1;
                byte_done <= &bit_cnt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            rx_shift <= {rx_shift[SPI_DATA_WIDTH-2:0], mosi_sync};
        end
        if (sclk_rise && &bit_cnt) begin
            rx_byte <= {rx_shift[SPI_DATA_WIDTH-2:0], mosi_sync};
        end
    end

    // -------------------------------------------------------------------------
    // Transmit side
    // -------------------------------------------------------------------------

    // First load waits two clocks after cs_fall so the hoarder holds word 0.
    // Later bytes load on the falling edge that follows a finished byte.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_q  <= '0;
            tx_shift <= '0;
        end else begin
            start_q <= {start_q[0], cs_fall};
            if (start_q[1]) begin
                tx_shift <= tx_byte;
            end else if (cs_rise) begin
                tx_shift <= '0;
            end else if (sclk_fall) begin
                if (bit_cnt == '0) begin
                    tx_shift <= tx_byte;
                end else begin
                    tx_shift <= {tx_shift[SPI_DATA_WIDTH-2:0], 1'b0};
                end
            end
        end
    end

    assign miso = tx_shift[SPI_DATA_WIDTH-1];

    // Master must not release cs within a clock of the last sampled edge
    a_byte_in_frame : assert property (
        @(posedge clk) disable iff (rst) byte_done |-> !cs_sync
    ) else $error("byte completed after cs was released");

endmodule

`default_nettype wire

//--- src/spi_pu_pkg.sv
`default_nettype none

package spi_pu_pkg;

    // -------------------------------------------------------------------------
    // Widths and sizes
    // -------------------------------------------------------------------------

    // Host word and SPI byte
    localparam int DATA_WIDTH     = 32;
    localparam int SPI_DATA_WIDTH = 8;

    // Attribute bits reported with every host read
    localparam int ATTR_WIDTH     = 4;

    // Words held by one buffer
    localparam int BUF_SIZE       = 6;
    localparam int BYTES_PER_WORD = DATA_WIDTH / SPI_DATA_WIDTH;

    // Attribute bit set when the receive buffer has nothing to read
    localparam int INVALID        = 0;

    // -------------------------------------------------------------------------
    // Typed vectors
    // -------------------------------------------------------------------------

    typedef logic [DATA_WIDTH-1:0]     word_t;
    typedef logic [SPI_DATA_WIDTH-1:0] spi_byte_t;
    typedef logic [ATTR_WIDTH-1:0]     attr_t;

    // Counts 0..BUF_SIZE, so a full buffer is distinct from an empty one
    typedef logic [$clog2(BUF_SIZE+1)-1:0] buf_ptr_t;

    // Byte position inside a word, 0 is the most significant byte
    typedef logic [$clog2(BYTES_PER_WORD)-1:0] byte_idx_t;

    // Link state seen by the control block
    typedef enum logic {
        LINK_IDLE,
        LINK_ACTIVE
    } link_state_t;

endpackage

`default_nettype wire
